// ==== hdl/vga_color_pkg.sv ====
`default_nettype none

package vga_color_pkg;

    //////////////////////////////
    // pixel format
    //////////////////////////////

    typedef struct packed {
        logic [4:0] r;      // red, msb side
        logic [5:0] g;      // green gets the extra bit
        logic [4:0] b;      // blue
    } rgb565_t;

    //////////////////////////////
    // bar colours, left to right
    //////////////////////////////

    typedef enum logic [$bits(rgb565_t)-1:0] {
        BAR_RED    = 16'hF800,
        BAR_ORANGE = 16'hFC00,
        BAR_YELLOW = 16'hFFE0,
        BAR_GREEN  = 16'h07E0,
        BAR_CYAN   = 16'h07FF,
        BAR_BLUE   = 16'h001F,
        BAR_PURPLE = 16'hF81F,
        BAR_BLACK  = 16'h0000,     // also used outside the active width
        BAR_WHITE  = 16'hFFFF,
        BAR_GRAY   = 16'hD69A
    } bar_color_e;

    // indexed by bar number, 0 at the left edge
    localparam rgb565_t BAR_PALETTE [10] = '{
        BAR_RED, BAR_ORANGE, BAR_YELLOW, BAR_GREEN, BAR_CYAN,
        BAR_BLUE, BAR_PURPLE, BAR_BLACK, BAR_WHITE, BAR_GRAY
    };

endpackage

`default_nettype wire

// ==== hdl/vga_colorbar.sv ====
`default_nettype none

module vga_colorbar (
    input  logic                   vga_clk,     // 25 MHz pixel clock
    input  logic                   sys_rst_n,
    output logic                   hsync,
    output logic                   vsync,
    output vga_color_pkg::rgb565_t rgb
);

    //////////////////////////////
    // internal wiring
    //////////////////////////////

    vga_timing_pkg::pix_coord_t pix_x;      // ctrl to pattern
    vga_timing_pkg::pix_coord_t pix_y;
    vga_color_pkg::rgb565_t     pix_data;   // pattern back to ctrl

    //////////////////////////////
    // timing controller
    //////////////////////////////

    vga_ctrl i_vga_ctrl (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pix_data  (pix_data),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    //////////////////////////////
    // pattern source
    //////////////////////////////

    vga_pic i_vga_pic (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_data  (pix_data)
    );

endmodule

`default_nettype wire

// ==== hdl/vga_ctrl.sv ====
`default_nettype none

`include "vga_settings.svh"

module vga_ctrl (
    input  logic                       vga_clk,
    input  logic                       sys_rst_n,
    input  vga_color_pkg::rgb565_t     pix_data,   // from pattern, one cycle after pix_x
    output vga_timing_pkg::pix_coord_t pix_x,      // next pixel column, FFF when idle
    output vga_timing_pkg::pix_coord_t pix_y,      // next pixel row, FFF when idle
    output logic                       hsync,
    output logic                       vsync,
    output vga_color_pkg::rgb565_t     rgb
);

    import vga_timing_pkg::*;

    //////////////////////////////
    // window limits
    //////////////////////////////

    localparam raster_cnt_t H_LAST = `VGA_H_TOTAL - 12'd1;     // 799
    localparam raster_cnt_t V_LAST = `VGA_V_TOTAL - 12'd1;     // 524

    // first active column, sync + back porch + left border
    localparam raster_cnt_t H_ACT_START = `VGA_H_SYNC + `VGA_H_BACK + `VGA_H_LEFT;
    localparam raster_cnt_t H_ACT_END   = H_ACT_START + `VGA_H_VALID;   // exclusive, 784

    localparam raster_cnt_t V_ACT_START = `VGA_V_SYNC + `VGA_V_BACK + `VGA_V_TOP;
    localparam raster_cnt_t V_ACT_END   = V_ACT_START + `VGA_V_VALID;   // exclusive, 515

    // request leads the active window by the pattern latency
    localparam raster_cnt_t H_REQ_START = H_ACT_START - 12'd1;     // 143
    localparam raster_cnt_t H_REQ_END   = H_ACT_END - 12'd1;       // 783

    raster_cnt_t cnt_h;         // column within line
    raster_cnt_t cnt_v;         // line within frame
    logic        h_active;
    logic        v_active;
    logic        pix_active;    // pixel on screen now
    logic        pix_req;       // pixel on screen next cycle

    //////////////////////////////
    // raster counters
    //////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_h <= '0;
        end else if (cnt_h == H_LAST) begin
            cnt_h <= '0;                    // line wrap
        end else begin
            cnt_h <= cnt_h + 12'd1;
        end
    end

    // one step per line, at the wrap of cnt_h
    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_v <= '0;
        end else if (cnt_h == H_LAST) begin
            if (cnt_v == V_LAST) begin
                cnt_v <= '0;                // frame wrap
            end else begin
                cnt_v <= cnt_v + 12'd1;
            end
        end
    end

    //////////////////////////////
    // sync and window decode
    //////////////////////////////

    // positive pulses at the start of line and frame
    assign hsync = (cnt_h < `VGA_H_SYNC);
    assign vsync = (cnt_v < `VGA_V_SYNC);

    assign h_active   = (cnt_h >= H_ACT_START) && (cnt_h < H_ACT_END);
    assign v_active   = (cnt_v >= V_ACT_START) && (cnt_v < V_ACT_END);
    assign pix_active = h_active && v_active;

    // same lines as the active window, columns one earlier
    assign pix_req = (cnt_h >= H_REQ_START) && (cnt_h < H_REQ_END) && v_active;

    //////////////////////////////
    // pixel request and output
    //////////////////////////////

    // coordinates relative to the top left active pixel
    assign pix_x = pix_req ? pix_coord_t'(cnt_h - H_REQ_START) : PIX_NONE;
    assign pix_y = pix_req ? pix_coord_t'(cnt_v - V_ACT_START) : PIX_NONE;

    // black in sync, porches and borders
    assign rgb = pix_active ? pix_data : '0;

endmodule

`default_nettype wire

// ==== hdl/vga_pic.sv ====
`default_nettype none

`include "vga_settings.svh"

module vga_pic (
    input  logic                       vga_clk,
    input  logic                       sys_rst_n,
    input  vga_timing_pkg::pix_coord_t pix_x,      // column of the next pixel
    input  vga_timing_pkg::pix_coord_t pix_y,      // row of the next pixel
    output vga_color_pkg::rgb565_t     pix_data    // registered colour, one cycle later
);

    import vga_color_pkg::*;

    //////////////////////////////
    // bar geometry
    //////////////////////////////

    // 640 / 10, each bar is 64 columns
    localparam int unsigned BAR_W = `VGA_H_VALID / `VGA_BAR_COUNT;
    localparam int unsigned IDX_W = $clog2(`VGA_BAR_COUNT);

    logic [IDX_W-1:0] bar_idx;      // bar under pix_x
    logic             in_range;     // pix_x, pix_y inside the active area

    // power of two width, so this is a plain shift
    assign bar_idx  = IDX_W'(pix_x / BAR_W);

    // FFF coordinates from the controller fall out here too
    assign in_range = (pix_x < `VGA_H_VALID) && (pix_y < `VGA_V_VALID);

    //////////////////////////////
    // colour register
    //////////////////////////////

    always_ff @(posedge vga_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            pix_data <= '0;
        end else if (in_range) begin
            pix_data <= BAR_PALETTE[bar_idx];   // palette entry for this bar
        end else begin
            pix_data <= BAR_BLACK;              // right of the last bar
        end
    end

endmodule

`default_nettype wire

// ==== hdl/vga_timing_pkg.sv ====
`default_nettype none

package vga_timing_pkg;

    //////////////////////////////
    // raster position
    //////////////////////////////

    // pixel coordinate inside the active area, x or y
    typedef logic [11:0] pix_coord_t;

    // value sent when no pixel is being requested
    localparam pix_coord_t PIX_NONE = 12'hFFF;

    //////////////////////////////
    // sync timing
    //////////////////////////////

    // horizontal and vertical counter value
    // 12 bits covers 800 cycles and 525 lines
    typedef logic [11:0] raster_cnt_t;

endpackage

`default_nettype wire

// ==== include/vga_settings.svh ====
`ifndef VGA_SETTINGS_SVH
`define VGA_SETTINGS_SVH

//////////////////////////////
// horizontal timing, in vga_clk cycles
//////////////////////////////

`define VGA_H_SYNC      12'd96      // hsync pulse
`define VGA_H_BACK      12'd40      // back porch
`define VGA_H_LEFT      12'd8       // left border
`define VGA_H_VALID     12'd640     // active pixels
`define VGA_H_RIGHT     12'd8       // right border
`define VGA_H_FRONT     12'd8       // front porch

// full line, 800 cycles
`define VGA_H_TOTAL     (`VGA_H_SYNC + `VGA_H_BACK + `VGA_H_LEFT + \
                         `VGA_H_VALID + `VGA_H_RIGHT + `VGA_H_FRONT)

//////////////////////////////
// vertical timing, in lines
//////////////////////////////

`define VGA_V_SYNC      12'd2       // vsync pulse
`define VGA_V_BACK      12'd25      // back porch
`define VGA_V_TOP       12'd8       // top border
`define VGA_V_VALID     12'd480     // active lines
`define VGA_V_BOTTOM    12'd8       // bottom border
`define VGA_V_FRONT     12'd2       // front porch

// full frame, 525 lines
`define VGA_V_TOTAL     (`VGA_V_SYNC + `VGA_V_BACK + `VGA_V_TOP + \
                         `VGA_V_VALID + `VGA_V_BOTTOM + `VGA_V_FRONT)

//////////////////////////////
// pattern
//////////////////////////////

`define VGA_BAR_COUNT   12'd10      // vertical bars across the active width

`endif

// ==== testbench/vga_colorbar_assertions.sv ====
`default_nettype none

`include "vga_settings.svh"

module vga_colorbar_assertions (
    input logic                        vga_clk,
    input logic                        sys_rst_n,
    input logic                        hsync,
    input logic                        vsync,
    input vga_color_pkg::rgb565_t      rgb,
    input vga_timing_pkg::raster_cnt_t cnt_h      // horizontal counter inside vga_ctrl
);

    localparam int H_SYNC = `VGA_H_SYNC;

    int unsigned fail_count = 0;        // failed assertions so far

    //////////////////////////////
    // sync and blanking rules
    //////////////////////////////

    // no colour during either pulse
    rgb_blank_in_sync: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        (hsync || vsync) |-> (rgb == '0)
    ) else begin
        $error("rgb is not black while a sync pulse is high");
        fail_count++;
    end

    hsync_width: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        $rose(hsync) |-> ##H_SYNC $fell(hsync)     // 96 cycles high
    ) else begin
        $error("hsync did not fall 96 cycles after it rose");
        fail_count++;
    end

    // vsync moves only at the line wrap
    vsync_at_line_start: assert property (
        @(posedge vga_clk) disable iff (!sys_rst_n)
        $changed(vsync) |-> (cnt_h == '0)
    ) else begin
        $error("vsync changed away from the start of a line");
        fail_count++;
    end

endmodule

bind vga_ctrl vga_colorbar_assertions i_assertions (
    .vga_clk   (vga_clk),
    .sys_rst_n (sys_rst_n),
    .hsync     (hsync),
    .vsync     (vsync),
    .rgb       (rgb),
    .cnt_h     (cnt_h)
);

`default_nettype wire

// ==== testbench/vga_colorbar_tb.sv ====
`default_nettype none

`include "vga_settings.svh"

module vga_colorbar_tb;

    import vga_color_pkg::*;

    //////////////////////////////
    // raster constants
    //////////////////////////////

    localparam int H_TOTAL = `VGA_H_TOTAL;                               // 800
    localparam int V_TOTAL = `VGA_V_TOTAL;                               // 525
    localparam int H_SYNC  = `VGA_H_SYNC;
    localparam int V_SYNC  = `VGA_V_SYNC;
    localparam int H_START = `VGA_H_SYNC + `VGA_H_BACK + `VGA_H_LEFT;    // 144
    localparam int V_START = `VGA_V_SYNC + `VGA_V_BACK + `VGA_V_TOP;     // 35
    localparam int H_VALID = `VGA_H_VALID;
    localparam int V_VALID = `VGA_V_VALID;
    localparam int BAR_W   = `VGA_H_VALID / `VGA_BAR_COUNT;              // 64 columns
    localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL;                   // two frames

    // one table row, coordinates relative to the top left active pixel
    typedef struct packed {
        int      x;         // negative left of the window
        int      y;         // negative above the window
        rgb565_t exp;
    } row_t;

    logic        vga_clk;
    logic        sys_rst_n;
    logic        hsync;
    logic        vsync;
    rgb565_t     rgb;

    row_t        rows[$];
    int          col;           // cycles since hsync rose
    int          line;          // lines since vsync rose
    logic        hs_prev;
    logic        vs_prev;
    logic        first;         // first sample after release
    int unsigned lcg_state;

    vga_colorbar i_dut (
        .vga_clk   (vga_clk),
        .sys_rst_n (sys_rst_n),
        .hsync     (hsync),
        .vsync     (vsync),
        .rgb       (rgb)
    );

    always #20 vga_clk = ~vga_clk;     // 40 unit period

    //////////////////////////////
    // compare and stop
    //////////////////////////////

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_rgb(input rgb565_t got, input rgb565_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED rgb at x %0d y %0d: got %h expected %h",
                     col - H_START, line - V_START, got, exp);
            stop_run();
        end
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s at col %0d line %0d: got %h expected %h",
                     name, col, line, got, exp);
            stop_run();
        end
    endtask

    //////////////////////////////
    // position model
    //////////////////////////////

    // called at a falling edge, where every output is settled
    task automatic sample_raster();
        logic hs_rise;
        logic vs_rise;
        hs_rise = hsync && !hs_prev;
        vs_rise = vsync && !vs_prev;
        if (hs_rise) begin
            if (!first) check_sync("hsync", hsync, col == H_TOTAL - 1);  // rise only after a full line
            col = 0;
            if (vs_rise) begin
                if (!first) check_sync("vsync", vsync, line == V_TOTAL - 1);
                line = 0;
            end else begin
                line++;
            end
        end else begin
            col++;
        end
        // pulse width, and edges that come late
        check_sync("hsync", hsync, (col < H_SYNC) || (col >= H_TOTAL));
        check_sync("vsync", vsync, (line < V_SYNC) || (line >= V_TOTAL));
        hs_prev = hsync;
        vs_prev = vsync;
        first   = 1'b0;
    endtask

    task automatic next_cycle();
        @(negedge vga_clk);
        sample_raster();
    endtask

    task automatic wait_position(input int x, input int y);
        int n;
        n = 0;
        while ((col != x + H_START) || (line != y + V_START)) begin
            if (n == WAIT_LIMIT) begin
                $display("timeout: the raster never reached x %0d y %0d", x, y);
                stop_run();
            end
            next_cycle();
            n++;
        end
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // bar colours, left to right
    localparam rgb565_t BAR_COLORS [10] = '{
        16'hF800, 16'hFC00, 16'hFFE0, 16'h07E0, 16'h07FF,
        16'h001F, 16'hF81F, 16'h0000, 16'hFFFF, 16'hD69A
    };

    // bar x/64 inside the window, black elsewhere
    function automatic rgb565_t expected_color(input int x, input int y);
        if ((x < 0) || (x >= H_VALID) || (y < 0) || (y >= V_VALID)) begin
            return '0;
        end
        return BAR_COLORS[x / BAR_W];
    endfunction

    task automatic add_row(input int x, input int y, input rgb565_t exp);
        row_t r;
        r.x   = x;
        r.y   = y;
        r.exp = exp;
        rows.push_back(r);
    endtask

    // raster order, so one frame covers the fixed rows
    task automatic load_table();
        int rx;
        int ry;
        add_row(-144, -35, 16'h0000);     // line 0 col 0, both syncs
        add_row( 100,  -1, 16'h0000);     // top border
        add_row(  -1,   0, 16'h0000);     // col 143, just left of the window
        add_row(   0,   0, 16'hF800);     // red
        add_row(  63,   0, 16'hF800);
        add_row(  64,   0, 16'hFC00);     // orange
        add_row( 127,   0, 16'hFC00);
        add_row(-100,  10, 16'h0000);     // inside the hsync pulse
        add_row( 128, 100, 16'hFFE0);     // yellow
        add_row( 320, 100, 16'h001F);     // blue
        add_row( 575, 239, 16'hFFFF);     // white, last column
        add_row( 576, 239, 16'hD69A);     // gray
        add_row( 639, 239, 16'hD69A);
        add_row( 640, 239, 16'h0000);     // col 784, right border
        add_row( 200, 300, 16'h07E0);     // green
        add_row( 260, 300, 16'h07FF);     // cyan
        add_row( 400, 300, 16'hF81F);     // purple
        add_row( 500, 300, 16'h0000);     // black bar
        add_row( 639, 479, 16'hD69A);     // last active pixel
        add_row(   0, 480, 16'h0000);     // bottom border
        add_row(-144, -35, 16'h0000);     // next frame, vsync period
        repeat (3) begin
            lcg_state = lcg_next(lcg_state);
            rx = int'((lcg_state >> 16) % H_VALID);
            lcg_state = lcg_next(lcg_state);
            ry = int'((lcg_state >> 16) % V_VALID);
            add_row(rx, ry, expected_color(rx, ry));
        end
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        vga_clk   = 1'b0;
        sys_rst_n = 1'b0;
        col       = 0;
        line      = 0;
        hs_prev   = 1'b0;
        vs_prev   = 1'b0;
        first     = 1'b1;
        lcg_state = 67;
        load_table();

        // three cycles in reset, screen stays black
        repeat (3) begin
            @(negedge vga_clk);
            check_rgb(rgb, '0);
        end
        sys_rst_n = 1'b1;
        sample_raster();            // counters still at zero
        check_sync("hsync", hsync, 1'b1);
        check_sync("vsync", vsync, 1'b1);

        foreach (rows[i]) begin
            wait_position(rows[i].x, rows[i].y);
            check_rgb(rgb, rows[i].exp);
        end

        if (i_dut.i_vga_ctrl.i_assertions.fail_count != 0) begin
            $display("%0d assertion failures during the run",
                     i_dut.i_vga_ctrl.i_assertions.fail_count);
            stop_run();
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== vga_colorbar.f ====
+incdir+include
hdl/vga_timing_pkg.sv
hdl/vga_color_pkg.sv
hdl/vga_ctrl.sv
hdl/vga_pic.sv
hdl/vga_colorbar.sv
testbench/vga_colorbar_assertions.sv
testbench/vga_colorbar_tb.sv
